// ==== Makefile ====
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
+incdir+logic
logic/id_pkg.sv
logic/id_stage_reg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/id_stage.sv
sim/id_stage_tb.sv

// ==== logic/branch_unit.sv ====
`timescale 1ns/100ps
`include "id_params.svh"

module branch_unit
    import id_pkg::*;
(
    input  if_to_id_t                       cur,
    input  ctrl_t                           ctrl,
    input  logic [`NUM_SRC-1:0][`XLEN-1:0]  operand,
    output id_to_ex_t                       id_to_ex,
    output br_t                             br
);

    logic [`XLEN-1:0] pc_plus_4;
    logic [`XLEN-1:0] br_target;
    logic [`XLEN-1:0] jump_target;
    logic             ops_equal;

    assign pc_plus_4   = cur.pc + `XLEN'd4;
    assign ops_equal   = (operand[0] == operand[1]);
    assign br_target   = pc_plus_4 + {ctrl.ext_imm[`XLEN-3:0], 2'b00};
    assign jump_target = {pc_plus_4[`XLEN-1:`XLEN-4], ctrl.jidx, 2'b00};

    always_comb begin
        br = '0;
        case (ctrl.br_kind)
            BR_BEQ: begin
                br.taken = ops_equal;
                br.addr  = br_target;
            end
            BR_BNE: begin
                br.taken = !ops_equal;
                br.addr  = br_target;
            end
            BR_J: begin
                br.taken = 1'b1;
                br.addr  = jump_target;
            end
            BR_JR: begin
                br.taken = 1'b1;
                br.addr  = operand[0];  // forwarded rs
            end
            default: ;
        endcase
        if (!br.taken) begin
            br.addr = '0;
        end
    end

    always_comb begin
        id_to_ex.valid    = cur.valid;
        id_to_ex.pc       = cur.pc;
        id_to_ex.alu_op   = ctrl.alu_op;
        id_to_ex.src1_sel = ctrl.src1_sel;
        id_to_ex.src2_sel = ctrl.src2_sel;
        id_to_ex.mem_en   = ctrl.mem_en;
        id_to_ex.mem_we   = ctrl.mem_we;
        id_to_ex.rf_we    = ctrl.rf_we;
        id_to_ex.rf_waddr = ctrl.rf_waddr;
        id_to_ex.ext_imm  = ctrl.ext_imm;
        id_to_ex.sa       = ctrl.sa;
        id_to_ex.rdata1   = operand[0];  // resolved values, not raw regfile
        id_to_ex.rdata2   = operand[1];
    end

endmodule

// ==== logic/id_params.svh ====
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// datapath and pc width
`define XLEN 32

// general purpose register file
`define NUM_REGS 32
`define REG_AW   5

// rs and rt
`define NUM_SRC 2

// jal writes its return address here
`define LINK_REG 31

`endif

// ==== logic/id_pkg.sv ====
`include "id_params.svh"

package id_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_sel_e;
    typedef enum logic [1:0] {SRC2_RT, SRC2_IMM, SRC2_EIGHT} src2_sel_e;

    // BR_J is shared by j and jal
    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JR} br_kind_e;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } if_to_id_t;

    typedef struct packed {
        logic id;
        logic ex;
    } stall_t;

    // one per ex, mem and wb stage
    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_e            alu_op;
        src1_sel_e          src1_sel;
        src2_sel_e          src2_sel;
        logic               mem_en;
        logic               mem_we;
        logic               rf_we;
        logic [`REG_AW-1:0] rf_waddr;
        br_kind_e           br_kind;
        logic [`XLEN-1:0]   ext_imm;
        logic [4:0]         sa;
        logic [25:0]        jidx;     // j/jal instr_index
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        alu_op_e            alu_op;
        src1_sel_e          src1_sel;
        src2_sel_e          src2_sel;
        logic               mem_en;
        logic               mem_we;
        logic               rf_we;
        logic [`REG_AW-1:0] rf_waddr;
        logic [`XLEN-1:0]   ext_imm;
        logic [4:0]         sa;
        logic [`XLEN-1:0]   rdata1;
        logic [`XLEN-1:0]   rdata2;
    } id_to_ex_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] addr;
    } br_t;

endpackage

// ==== logic/id_stage.sv ====
`timescale 1ns/100ps
`include "id_params.svh"

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  if_to_id_t if_to_id,
    input  stall_t    stall,
    input  fwd_t      ex_fwd,
    input  fwd_t      mem_fwd,
    input  fwd_t      wb_fwd,       // also the regfile write port
    input  logic      ex_is_load,
    output id_to_ex_t id_to_ex,
    output br_t       br,
    output logic      stall_req
);

    if_to_id_t                          cur;
    ctrl_t                              ctrl;
    logic [`NUM_SRC-1:0][`REG_AW-1:0]   src_addr;   // [0] rs, [1] rt
    logic [`NUM_SRC-1:0][`XLEN-1:0]     rf_rdata;
    logic [`NUM_SRC-1:0][`XLEN-1:0]     operand;

    id_stage_reg u_stage_reg (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .d     (if_to_id),
        .q     (cur)
    );

    inst_decoder u_decoder (
        .cur        (cur),
        .ex_fwd     (ex_fwd),
        .ex_is_load (ex_is_load),
        .rs         (src_addr[0]),
        .rt         (src_addr[1]),
        .ctrl       (ctrl),
        .stall_req  (stall_req)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .raddr (src_addr),
        .rdata (rf_rdata),
        .wr    (wb_fwd)
    );

    for (genvar i = 0; i < `NUM_SRC; i++) begin : g_fwd
        operand_forward u_fwd (
            .raddr   (src_addr[i]),
            .rf_data (rf_rdata[i]),
            .ex_fwd  (ex_fwd),
            .mem_fwd (mem_fwd),
            .wb_fwd  (wb_fwd),
            .operand (operand[i])
        );
    end

    branch_unit u_branch (
        .cur      (cur),
        .ctrl     (ctrl),
        .operand  (operand),
        .id_to_ex (id_to_ex),
        .br       (br)
    );

endmodule

// ==== logic/id_stage_reg.sv ====
`timescale 1ns/100ps

module id_stage_reg
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  stall_t    stall,
    input  if_to_id_t d,
    output if_to_id_t q
);

    // load, bubble or hold under the controller's stall bits
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (!stall.id) begin
            q <= d;
        end else if (!stall.ex) begin
            q <= '0;    // id stalled but ex moves on, so insert a bubble
        end
        // both stalled: hold
    end

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/100ps
`include "id_params.svh"

module inst_decoder
    import id_pkg::*;
(
    input  if_to_id_t          cur,
    input  fwd_t               ex_fwd,
    input  logic               ex_is_load,
    output logic [`REG_AW-1:0] rs,
    output logic [`REG_AW-1:0] rt,
    output ctrl_t              ctrl,
    output logic               stall_req
);

    opcode_e            opcode;
    funct_e             funct;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   imm_sext;
    logic [`XLEN-1:0]   imm_zext;
    logic [`XLEN-1:0]   imm_upper;
    logic               reads_rs;   // source really used by this instruction
    logic               reads_rt;
    logic               rs_hit;
    logic               rt_hit;

    assign opcode = opcode_e'(cur.inst[31:26]);
    assign funct  = funct_e'(cur.inst[5:0]);
    assign rs     = cur.inst[25:21];
    assign rt     = cur.inst[20:16];
    assign rd     = cur.inst[15:11];

    assign imm_sext  = {{(`XLEN-16){cur.inst[15]}}, cur.inst[15:0]};
    assign imm_zext  = {{(`XLEN-16){1'b0}}, cur.inst[15:0]};
    assign imm_upper = {cur.inst[15:0], {(`XLEN-16){1'b0}}};

    always_comb begin
        ctrl      = '0;     // NOP, every enable low
        ctrl.sa   = cur.inst[10:6];
        ctrl.jidx = cur.inst[25:0];
        reads_rs  = 1'b0;
        reads_rt  = 1'b0;
        if (cur.valid) begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_ADDU: ctrl.alu_op = ALU_ADD;
                        FN_SUBU: ctrl.alu_op = ALU_SUB;
                        FN_AND:  ctrl.alu_op = ALU_AND;
                        FN_OR:   ctrl.alu_op = ALU_OR;
                        FN_XOR:  ctrl.alu_op = ALU_XOR;
                        FN_NOR:  ctrl.alu_op = ALU_NOR;
                        FN_SLT:  ctrl.alu_op = ALU_SLT;
                        FN_SLTU: ctrl.alu_op = ALU_SLTU;
                        FN_SLL:  ctrl.alu_op = ALU_SLL;
                        FN_SRL:  ctrl.alu_op = ALU_SRL;
                        FN_SRA:  ctrl.alu_op = ALU_SRA;
                        FN_JR:   ctrl.br_kind = BR_JR;
                        default: ;
                    endcase
                    if (ctrl.alu_op != ALU_NOP) begin
                        ctrl.rf_we    = 1'b1;
                        ctrl.rf_waddr = rd;
                        reads_rt      = 1'b1;
                        // shifts take the amount from sa, not rs
                        if (ctrl.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                            ctrl.src1_sel = SRC1_SA;
                        end else begin
                            reads_rs = 1'b1;
                        end
                    end
                    if (ctrl.br_kind == BR_JR) begin
                        reads_rs = 1'b1;
                    end
                end
                OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                    case (opcode)
                        OP_SLTI:  ctrl.alu_op = ALU_SLT;
                        OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                        OP_ANDI:  ctrl.alu_op = ALU_AND;
                        OP_ORI:   ctrl.alu_op = ALU_OR;
                        OP_XORI:  ctrl.alu_op = ALU_XOR;
                        OP_LUI:   ctrl.alu_op = ALU_LUI;
                        default:  ctrl.alu_op = ALU_ADD;  // addiu, lw address
                    endcase
                    case (opcode)
                        OP_ANDI, OP_ORI, OP_XORI: ctrl.ext_imm = imm_zext;
                        OP_LUI:                   ctrl.ext_imm = imm_upper;
                        default:                  ctrl.ext_imm = imm_sext;
                    endcase
                    ctrl.src2_sel = SRC2_IMM;
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = rt;
                    ctrl.mem_en   = (opcode == OP_LW);
                    reads_rs      = (opcode != OP_LUI);
                end
                OP_SW: begin
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.src2_sel = SRC2_IMM;
                    ctrl.ext_imm  = imm_sext;
                    ctrl.mem_en   = 1'b1;
                    ctrl.mem_we   = 1'b1;
                    reads_rs      = 1'b1;
                    reads_rt      = 1'b1;   // store data
                end
                OP_BEQ, OP_BNE: begin
                    ctrl.br_kind = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                    ctrl.ext_imm = imm_sext;
                    reads_rs     = 1'b1;
                    reads_rt     = 1'b1;
                end
                OP_J: ctrl.br_kind = BR_J;
                OP_JAL: begin
                    // link value pc+8 built in ex from pc and eight
                    ctrl.br_kind  = BR_J;
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.src1_sel = SRC1_PC;
                    ctrl.src2_sel = SRC2_EIGHT;
                    ctrl.rf_we    = 1'b1;
                    ctrl.rf_waddr = `REG_AW'(`LINK_REG);
                end
                default: ;
            endcase
        end
    end

    // load in ex feeding a source read here
    assign rs_hit    = reads_rs && (ex_fwd.waddr == rs);
    assign rt_hit    = reads_rt && (ex_fwd.waddr == rt);
    assign stall_req = ex_is_load && (ex_fwd.waddr != '0) && (rs_hit || rt_hit);

endmodule

// ==== logic/operand_forward.sv ====
`timescale 1ns/100ps
`include "id_params.svh"

module operand_forward
    import id_pkg::*;
(
    input  logic [`REG_AW-1:0] raddr,
    input  logic [`XLEN-1:0]   rf_data,
    input  fwd_t               ex_fwd,
    input  fwd_t               mem_fwd,
    input  fwd_t               wb_fwd,
    output logic [`XLEN-1:0]   operand
);

    logic nonzero;
    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    assign nonzero = (raddr != '0);     // r0 is never forwarded
    assign ex_hit  = nonzero && ex_fwd.we && (ex_fwd.waddr == raddr);
    assign mem_hit = nonzero && mem_fwd.we && (mem_fwd.waddr == raddr);
    assign wb_hit  = nonzero && wb_fwd.we && (wb_fwd.waddr == raddr);

    // youngest producer wins
    always_comb begin
        if (ex_hit) begin
            operand = ex_fwd.wdata;
        end else if (mem_hit) begin
            operand = mem_fwd.wdata;
        end else if (wb_hit) begin
            operand = wb_fwd.wdata;     // covers the write landing this edge
        end else begin
            operand = rf_data;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps
`include "id_params.svh"

module reg_file
    import id_pkg::*;
(
    input  logic                                clk,
    input  logic [`NUM_SRC-1:0][`REG_AW-1:0]    raddr,
    output logic [`NUM_SRC-1:0][`XLEN-1:0]      rdata,
    input  fwd_t                                wr
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // writes to r0 are dropped
    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // async read, r0 hardwired to zero
    always_comb begin
        for (int i = 0; i < `NUM_SRC; i++) begin
            rdata[i] = (raddr[i] == '0) ? '0 : regs[raddr[i]];
        end
    end

endmodule

// ==== sim/id_stage_tb.sv ====
`timescale 1ns/100ps
`include "id_params.svh"

module id_stage_tb
    import id_pkg::*;
();

    localparam int MAX_CASES  = 64;
    localparam int MAX_CYCLES = 1000;

    // table row with stimulus first and expected response after
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [31:0]        inst;
        stall_t             stall;
        fwd_t               ex;
        fwd_t               mem;
        fwd_t               wb;
        logic               ld;
        logic               exp_valid;
        logic [`XLEN-1:0]   exp_pc;
        alu_op_e            exp_alu;
        logic               exp_we;
        logic [`REG_AW-1:0] exp_waddr;
        logic [`XLEN-1:0]   exp_imm;
        logic [`XLEN-1:0]   exp_rd1;
        logic [`XLEN-1:0]   exp_rd2;
        logic               exp_taken;
        logic [`XLEN-1:0]   exp_addr;
        logic               exp_sreq;
        logic               exp_mem_en;
        logic               exp_mem_we;
        logic               chk_sel;
        src1_sel_e          exp_src1;
        src2_sel_e          exp_src2;
        logic               chk_sa;
        logic [4:0]         exp_sa;
    } case_t;

    logic      clk;
    logic      rst;
    if_to_id_t if_to_id;
    stall_t    stall;
    fwd_t      ex_fwd;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;
    logic      ex_is_load;
    id_to_ex_t id_to_ex;
    br_t       br;
    logic      stall_req;

    case_t            tbl [MAX_CASES];
    string            case_name [MAX_CASES];
    int               n_cases;
    logic [`XLEN-1:0] rf_model [`NUM_REGS];   // expected register file contents
    int               n_checks;
    int               n_errors;
    int               n_other;

    id_stage dut (
        .clk        (clk),
        .rst        (rst),
        .if_to_id   (if_to_id),
        .stall      (stall),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .id_to_ex   (id_to_ex),
        .br         (br),
        .stall_req  (stall_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog for the whole run
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                          input int sa, input funct_e fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] enc_j(input opcode_e op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic fwd_t mk_fwd(input int we, input int waddr, input logic [31:0] wdata);
        fwd_t f;
        f.we    = 1'(we);
        f.waddr = `REG_AW'(waddr);
        f.wdata = wdata;
        return f;
    endfunction

    // ex before mem before wb and r0 never forwarded
    function automatic logic [31:0] fwd_read(input logic [4:0] idx, input fwd_t ex,
                                             input fwd_t mem, input fwd_t wb);
        if (idx == '0) return '0;
        if (ex.we && ex.waddr == idx) return ex.wdata;
        if (mem.we && mem.waddr == idx) return mem.wdata;
        if (wb.we && wb.waddr == idx) return wb.wdata;
        return rf_model[idx];
    endfunction

    task automatic add_case(input string name, input logic [31:0] pc, input logic [31:0] inst,
                            input alu_op_e alu, input int we, input int waddr,
                            input logic [31:0] imm);
        case_t c;
        c           = '0;
        c.pc        = pc;
        c.inst      = inst;
        c.exp_valid = 1'b1;
        c.exp_pc    = pc;
        c.exp_alu   = alu;
        c.exp_we    = 1'(we);
        c.exp_waddr = `REG_AW'(waddr);
        c.exp_imm   = imm;
        tbl[n_cases]       = c;
        case_name[n_cases] = name;
        n_cases++;
    endtask

    task automatic with_fwd(input fwd_t ex, input fwd_t mem, input fwd_t wb);
        tbl[n_cases-1].ex  = ex;
        tbl[n_cases-1].mem = mem;
        tbl[n_cases-1].wb  = wb;
    endtask

    task automatic with_load(input int sreq);
        tbl[n_cases-1].ld       = 1'b1;
        tbl[n_cases-1].exp_sreq = 1'(sreq);
    endtask

    task automatic with_br(input int taken, input logic [31:0] addr);
        tbl[n_cases-1].exp_taken = 1'(taken);
        tbl[n_cases-1].exp_addr  = addr;
    endtask

    task automatic with_mem(input int en, input int we);
        tbl[n_cases-1].exp_mem_en = 1'(en);
        tbl[n_cases-1].exp_mem_we = 1'(we);
    endtask

    task automatic with_sel(input src1_sel_e s1, input src2_sel_e s2);
        tbl[n_cases-1].chk_sel  = 1'b1;
        tbl[n_cases-1].exp_src1 = s1;
        tbl[n_cases-1].exp_src2 = s2;
    endtask

    task automatic with_sa(input int sa);
        tbl[n_cases-1].chk_sa = 1'b1;
        tbl[n_cases-1].exp_sa = 5'(sa);
    endtask

    task automatic with_stall(input int id, input int ex);
        tbl[n_cases-1].stall.id = 1'(id);
        tbl[n_cases-1].stall.ex = 1'(ex);
    endtask

    // walks the table as the stage register would and fills in operands and wb writes
    task automatic finish_table();
        case_t       stim;
        logic [31:0] held;
        held = '0;
        for (int i = 0; i < n_cases; i++) begin
            stim = tbl[i];
            if (!stim.stall.id) begin
                held = stim.inst;
            end else if (!stim.stall.ex) begin
                held   = '0;        // bubble
                tbl[i] = '0;
            end else if (i > 0) begin
                tbl[i] = tbl[i-1];  // held word decodes as before
            end
            tbl[i].pc      = stim.pc;
            tbl[i].inst    = stim.inst;
            tbl[i].stall   = stim.stall;
            tbl[i].ex      = stim.ex;
            tbl[i].mem     = stim.mem;
            tbl[i].wb      = stim.wb;
            tbl[i].ld      = stim.ld;
            tbl[i].exp_rd1 = fwd_read(held[25:21], stim.ex, stim.mem, stim.wb);
            tbl[i].exp_rd2 = fwd_read(held[20:16], stim.ex, stim.mem, stim.wb);
            if (stim.wb.we && stim.wb.waddr != '0) begin
                rf_model[stim.wb.waddr] = stim.wb.wdata;
            end
        end
    endtask

    task automatic check_field(input string tname, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("ERROR %s %s: expected %h, actual %h", tname, field, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_case(input int i);
        case_t c;
        string nm;
        c  = tbl[i];
        nm = case_name[i];
        check_field(nm, "valid", 32'(c.exp_valid), 32'(id_to_ex.valid));
        check_field(nm, "pc", c.exp_pc, id_to_ex.pc);
        check_field(nm, "alu_op", 32'(c.exp_alu), 32'(id_to_ex.alu_op));
        check_field(nm, "rf_we", 32'(c.exp_we), 32'(id_to_ex.rf_we));
        check_field(nm, "rf_waddr", 32'(c.exp_waddr), 32'(id_to_ex.rf_waddr));
        check_field(nm, "ext_imm", c.exp_imm, id_to_ex.ext_imm);
        check_field(nm, "rdata1", c.exp_rd1, id_to_ex.rdata1);
        check_field(nm, "rdata2", c.exp_rd2, id_to_ex.rdata2);
        check_field(nm, "mem_en", 32'(c.exp_mem_en), 32'(id_to_ex.mem_en));
        check_field(nm, "mem_we", 32'(c.exp_mem_we), 32'(id_to_ex.mem_we));
        check_field(nm, "taken", 32'(c.exp_taken), 32'(br.taken));
        check_field(nm, "addr", c.exp_addr, br.addr);
        check_field(nm, "stall_req", 32'(c.exp_sreq), 32'(stall_req));
        if (c.chk_sel) begin
            check_field(nm, "src1_sel", 32'(c.exp_src1), 32'(id_to_ex.src1_sel));
            check_field(nm, "src2_sel", 32'(c.exp_src2), 32'(id_to_ex.src2_sel));
        end
        if (c.chk_sa) begin
            check_field(nm, "sa", 32'(c.exp_sa), 32'(id_to_ex.sa));
        end
    endtask

    task automatic check_idle();
        n_checks++;
        assert (!id_to_ex.valid && !id_to_ex.rf_we && !id_to_ex.mem_en && !id_to_ex.mem_we
                && !br.taken && !stall_req) else begin
            $display("after reset the stage shows a valid word or an enable set high");
            n_other++;
        end
    endtask

    initial begin
        logic [31:0] fa;
        logic [31:0] fb;
        logic [31:0] fc;
        logic [31:0] fd;
        logic [31:0] fe;
        void'($urandom(32'h8aee4f1d));
        rst        = 1'b1;
        if_to_id   = '0;
        stall      = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_is_load = 1'b0;
        n_cases    = 0;
        n_checks   = 0;
        n_errors   = 0;
        n_other    = 0;
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end
        #1 rst = 1'b0;
        @(posedge clk);
        #4 check_idle();

        // preload every register through the wb port
        rf_model[0] = '0;
        for (int r = 1; r < `NUM_REGS; r++) begin
            rf_model[r] = $urandom;
        end
        rf_model[6] = rf_model[5] ^ 32'h1;   // r5 and r6 must differ
        for (int r = 1; r < `NUM_REGS; r++) begin
            @(posedge clk);
            #1 wb_fwd = mk_fwd(1, r, rf_model[r]);
        end
        @(posedge clk);
        #1 wb_fwd = '0;
        fa = $urandom;
        fb = $urandom;
        fc = $urandom;
        fd = $urandom;
        fe = $urandom;

        add_case("addu", 32'h0040_0000, enc_r(1, 2, 3, 0, FN_ADDU), ALU_ADD, 1, 3, 32'h0);
        with_sel(SRC1_RS, SRC2_RT);
        add_case("subu", 32'h0040_0004, enc_r(4, 5, 7, 0, FN_SUBU), ALU_SUB, 1, 7, 32'h0);
        add_case("and", 32'h0040_0008, enc_r(6, 7, 8, 0, FN_AND), ALU_AND, 1, 8, 32'h0);
        add_case("or", 32'h0040_000c, enc_r(8, 9, 9, 0, FN_OR), ALU_OR, 1, 9, 32'h0);
        add_case("xor", 32'h0040_0010, enc_r(10, 11, 12, 0, FN_XOR), ALU_XOR, 1, 12, 32'h0);
        add_case("nor", 32'h0040_0014, enc_r(12, 13, 14, 0, FN_NOR), ALU_NOR, 1, 14, 32'h0);
        add_case("slt", 32'h0040_0018, enc_r(14, 15, 16, 0, FN_SLT), ALU_SLT, 1, 16, 32'h0);
        add_case("sltu", 32'h0040_001c, enc_r(16, 17, 18, 0, FN_SLTU), ALU_SLTU, 1, 18, 32'h0);
        add_case("sll", 32'h0040_0020, enc_r(0, 4, 10, 5, FN_SLL), ALU_SLL, 1, 10, 32'h0);
        with_sel(SRC1_SA, SRC2_RT);
        with_sa(5);
        add_case("srl", 32'h0040_0024, enc_r(0, 19, 11, 31, FN_SRL), ALU_SRL, 1, 11, 32'h0);
        with_sa(31);
        add_case("sra", 32'h0040_0028, enc_r(0, 20, 13, 1, FN_SRA), ALU_SRA, 1, 13, 32'h0);
        add_case("addu_r0", 32'h0040_002c, enc_r(0, 0, 12, 0, FN_ADDU), ALU_ADD, 1, 12, 32'h0);
        add_case("addiu", 32'h0040_0030, enc_i(OP_ADDIU, 2, 13, 16'hfff0), ALU_ADD, 1, 13,
                 32'hffff_fff0);
        with_sel(SRC1_RS, SRC2_IMM);
        add_case("slti", 32'h0040_0034, enc_i(OP_SLTI, 3, 14, 16'h8001), ALU_SLT, 1, 14,
                 32'hffff_8001);
        add_case("andi", 32'h0040_0038, enc_i(OP_ANDI, 4, 15, 16'h8001), ALU_AND, 1, 15,
                 32'h0000_8001);
        add_case("ori", 32'h0040_003c, enc_i(OP_ORI, 5, 16, 16'hf0f0), ALU_OR, 1, 16,
                 32'h0000_f0f0);
        add_case("xori", 32'h0040_0040, enc_i(OP_XORI, 6, 17, 16'h1234), ALU_XOR, 1, 17,
                 32'h0000_1234);
        add_case("lui", 32'h0040_0044, enc_i(OP_LUI, 0, 14, 16'habcd), ALU_LUI, 1, 14,
                 32'habcd_0000);
        add_case("lw", 32'h0040_0048, enc_i(OP_LW, 3, 15, 16'h0010), ALU_ADD, 1, 15, 32'h10);
        with_mem(1, 0);
        // store has no destination so waddr stays zero
        add_case("sw", 32'h0040_004c, enc_i(OP_SW, 3, 15, 16'hfffc), ALU_ADD, 0, 0,
                 32'hffff_fffc);
        with_mem(1, 1);

        add_case("fwd_ex", 32'h0040_0100, enc_r(16, 17, 18, 0, FN_ADDU), ALU_ADD, 1, 18, 32'h0);
        with_fwd(mk_fwd(1, 16, fa), mk_fwd(1, 16, fb), mk_fwd(1, 16, fc));
        add_case("fwd_mem", 32'h0040_0104, enc_r(16, 17, 18, 0, FN_ADDU), ALU_ADD, 1, 18, 32'h0);
        with_fwd('0, mk_fwd(1, 16, fb), mk_fwd(1, 16, fc));
        // r16 already holds fc from the rows above
        add_case("fwd_wb", 32'h0040_0108, enc_r(16, 17, 18, 0, FN_ADDU), ALU_ADD, 1, 18, 32'h0);
        with_fwd('0, '0, mk_fwd(1, 16, ~fc));
        add_case("fwd_rf", 32'h0040_010c, enc_r(16, 17, 18, 0, FN_ADDU), ALU_ADD, 1, 18, 32'h0);
        add_case("fwd_r0", 32'h0040_0110, enc_r(0, 17, 18, 0, FN_ADDU), ALU_ADD, 1, 18, 32'h0);
        with_fwd(mk_fwd(1, 0, fa), mk_fwd(1, 0, fb), mk_fwd(1, 0, fc));

        add_case("beq_taken", 32'h0040_0200, enc_i(OP_BEQ, 5, 5, 16'h0010), ALU_NOP, 0, 0,
                 32'h10);
        with_br(1, 32'h0040_0244);
        add_case("beq_not", 32'h0040_0204, enc_i(OP_BEQ, 5, 6, 16'hfff8), ALU_NOP, 0, 0,
                 32'hffff_fff8);
        add_case("bne_taken", 32'h0040_0300, enc_i(OP_BNE, 5, 6, 16'hfff8), ALU_NOP, 0, 0,
                 32'hffff_fff8);
        with_br(1, 32'h0040_02e4);
        add_case("bne_not", 32'h0040_0304, enc_i(OP_BNE, 5, 5, 16'h0040), ALU_NOP, 0, 0,
                 32'h40);
        add_case("j", 32'h9000_0100, enc_j(OP_J, 26'h012_3456), ALU_NOP, 0, 0, 32'h0);
        with_br(1, 32'h9048_d158);
        add_case("jal", 32'h4000_0ffc, enc_j(OP_JAL, 26'h3ff_ffff), ALU_ADD, 1, 31, 32'h0);
        with_br(1, 32'h4fff_fffc);
        with_sel(SRC1_PC, SRC2_EIGHT);
        add_case("jr", 32'h0040_0400, enc_r(7, 0, 0, 0, FN_JR), ALU_NOP, 0, 0, 32'h0);
        with_fwd(mk_fwd(1, 7, fd), '0, '0);
        with_br(1, fd);

        add_case("lu_rs", 32'h0040_0500, enc_r(20, 21, 22, 0, FN_ADDU), ALU_ADD, 1, 22, 32'h0);
        with_fwd(mk_fwd(1, 20, fe), '0, '0);
        with_load(1);
        add_case("lu_rt", 32'h0040_0504, enc_r(20, 21, 22, 0, FN_ADDU), ALU_ADD, 1, 22, 32'h0);
        with_fwd(mk_fwd(1, 21, fe), '0, '0);
        with_load(1);
        add_case("lu_imm_rt", 32'h0040_0508, enc_i(OP_ADDIU, 20, 21, 16'h0004), ALU_ADD, 1, 21,
                 32'h4);
        with_fwd(mk_fwd(1, 21, fe), '0, '0);
        with_load(0);
        add_case("lu_r0", 32'h0040_050c, enc_r(0, 21, 22, 0, FN_ADDU), ALU_ADD, 1, 22, 32'h0);
        with_fwd(mk_fwd(1, 0, fe), '0, '0);
        with_load(0);
        add_case("lu_sw_rt", 32'h0040_0510, enc_i(OP_SW, 3, 21, 16'h0008), ALU_ADD, 0, 0, 32'h8);
        with_fwd(mk_fwd(1, 21, fe), '0, '0);
        with_load(1);
        with_mem(1, 1);

        add_case("pre_hold", 32'h0040_0600, enc_r(1, 2, 3, 0, FN_ADDU), ALU_ADD, 1, 3, 32'h0);
        add_case("hold", 32'h0040_0604, enc_r(9, 9, 9, 0, FN_XOR), ALU_NOP, 0, 0, 32'h0);
        with_stall(1, 1);
        add_case("bubble", 32'h0040_0608, enc_r(4, 5, 6, 0, FN_SUBU), ALU_NOP, 0, 0, 32'h0);
        with_stall(1, 0);
        add_case("after_bubble", 32'h0040_060c, enc_i(OP_ORI, 8, 9, 16'h00ff), ALU_OR, 1, 9,
                 32'h0000_00ff);
        finish_table();

        // one word per two cycles and checked after the edge that loads it
        for (int i = 0; i < n_cases; i++) begin
            @(posedge clk);
            #1;
            if_to_id.valid = 1'b1;
            if_to_id.pc    = tbl[i].pc;
            if_to_id.inst  = tbl[i].inst;
            stall          = tbl[i].stall;
            @(posedge clk);
            #1;
            // later stages as seen while the word sits in id
            ex_fwd     = tbl[i].ex;
            mem_fwd    = tbl[i].mem;
            wb_fwd     = tbl[i].wb;
            ex_is_load = tbl[i].ld;
            #3 check_case(i);
        end

        $display("checks %0d, value errors %0d, other errors %0d", n_checks, n_errors, n_other);
        if (n_errors == 0 && n_other == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
